// ==== airHockeyCases.txt ====
# step sw btnU btnD num expUserY expAudioY | probe x y expColour(hex)
# run cycles expGameOver | puck and scores come from the testbench model
probe 48 32 ffff
probe 49 33 ffff
probe 3 32 f800
probe 92 42 001f
probe 92 43 0000
probe 47 10 8410
probe 48 11 0000
probe 5 32 0000
step 1 1 0 0 26 54
step 1 1 0 0 20 54
step 1 1 0 0 14 54
step 1 1 0 0 10 54
step 1 1 0 5 10 39
step 1 0 1 15 16 10
step 1 0 1 14 22 12
step 1 0 1 0 28 54
step 1 0 1 0 34 54
step 1 0 1 0 40 54
step 1 0 1 0 46 54
step 1 0 1 0 52 54
step 1 0 1 0 53 54
step 1 1 1 0 47 54
step 0 0 0 0 32 32
step 1 0 1 0 38 54
step 1 0 0 0 38 54
run 41 0
probe 4 48 ffff
probe 4 46 f800
run 620 1
step 0 0 0 0 32 32
probe 48 32 ffff

// ==== flist.f ====
airHockeyPkg.sv
airHockeyPaddles.sv
airHockeyPuck.sv
airHockeyScore.sv
airHockeyRenderer.sv
airHockeyTop.sv
tbClockGen.sv
airHockeyTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the air hockey testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module airHockeyTb \
    -Mdir obj_dir -o simAirHockey
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/simAirHockey
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// ==== airHockeyTb.sv ====
`timescale 1ns/1ps

module airHockeyTb;
    import airHockeyPkg::*;

    // Case file op codes and record size
    localparam int OpStep = 0;
    localparam int OpProbe = 1;
    localparam int OpRun = 2;
    localparam int CaseFields = 7;
    // Game rules followed by the model
    localparam int MaxScore = 7;
    localparam int UserHitX = 5;
    localparam int AudioHitX = 89;
    localparam int RightEdgeX = 94;
    localparam int WallLowY = 1;
    localparam int WallHighY = 62;
    localparam int PaddleReach = 10;

    logic clkPaddle;
    logic rstN;
    logic sw;
    logic btnU;
    logic btnD;
    logic [3:0] num;
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
    logic [15:0] pixelColour;
    logic [CoordWidth-1:0] userPaddleY;
    logic [CoordWidth-1:0] audioPaddleY;
    logic [CoordWidth-1:0] puckX;
    logic [CoordWidth-1:0] puckY;
    logic [3:0] userScore;
    logic [3:0] audioScore;
    logic gameOver;

    // Parsed cases with CaseFields ints per record
    int caseQ[$];
    int watchdogCycles = 0;

    // Expected puck and score state
    int modelX;
    int modelY;
    int modelDx;
    int modelDy;
    int modelUserScore;
    int modelAudioScore;
    int modelUserPadY;
    int modelAudioPadY;
    bit modelUserGoal;
    bit modelAudioGoal;

    tbClockGen #(.PeriodNs(4)) tbClockGen_i (.clkPaddle(clkPaddle));

    airHockeyTop #(
        .PaddleStep(6),
        .AudioStep(3),
        .MaxScore(MaxScore)
    ) airHockeyTop_i (
        .clkPaddle(clkPaddle), .rstN(rstN), .sw(sw), .btnU(btnU), .btnD(btnD),
        .num(num), .x(x), .y(y), .pixelColour(pixelColour),
        .userPaddleY(userPaddleY), .audioPaddleY(audioPaddleY),
        .puckX(puckX), .puckY(puckY), .userScore(userScore),
        .audioScore(audioScore), .gameOver(gameOver)
    );

    //////////////////////////////////////////////////
    // Puck and score model
    //////////////////////////////////////////////////

    function automatic bit withinReach(input int puckRow, input int padRow);
        return (puckRow >= padRow - PaddleReach) && (puckRow <= padRow + PaddleReach);
    endfunction

    function automatic bit modelOver();
        return (modelUserScore >= MaxScore) || (modelAudioScore >= MaxScore);
    endfunction

    // Serve spot heading left and down
    task automatic resetModel();
        modelX = CentreX;
        modelY = CentreY;
        modelDx = -1;
        modelDy = 1;
        modelUserScore = 0;
        modelAudioScore = 0;
        modelUserGoal = 1'b0;
        modelAudioGoal = 1'b0;
    endtask

    // One game step with all decisions on pre-edge state
    task automatic advanceModel();
        int aheadY;
        bit newUserGoal;
        bit newAudioGoal;
        newUserGoal = 1'b0;
        newAudioGoal = 1'b0;
        if (!sw) begin
            resetModel();
        end else if (!modelOver()) begin
            // Last step's strobes reach the counters now
            if (modelUserGoal) begin
                modelUserScore++;
            end
            if (modelAudioGoal) begin
                modelAudioScore++;
            end
            if (modelDx < 0 && modelX == 0) begin
                newAudioGoal = 1'b1;
                modelX = CentreX;
                modelY = CentreY;
                modelDx = 1;
            end else if (modelDx > 0 && modelX == RightEdgeX) begin
                newUserGoal = 1'b1;
                modelX = CentreX;
                modelY = CentreY;
                modelDx = -1;
            end else begin
                // Wall flip before the move
                aheadY = modelY + modelDy;
                if (aheadY < WallLowY || aheadY > WallHighY) begin
                    modelDy = -modelDy;
                end
                if (modelDx < 0 && modelX == UserHitX && withinReach(modelY, modelUserPadY)) begin
                    modelDx = 1;
                end else if (modelDx > 0 && modelX == AudioHitX
                             && withinReach(modelY, modelAudioPadY)) begin
                    modelDx = -1;
                end
                modelX += modelDx;
                modelY += modelDy;
            end
        end
        modelUserGoal = newUserGoal;
        modelAudioGoal = newAudioGoal;
    endtask

    //////////////////////////////////////////////////
    // Checks and clocking
    //////////////////////////////////////////////////

    task automatic checkValue(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic checkState();
        checkValue("puckX", int'(puckX), modelX);
        checkValue("puckY", int'(puckY), modelY);
        checkValue("userScore", int'(userScore), modelUserScore);
        checkValue("audioScore", int'(audioScore), modelAudioScore);
        checkValue("gameOver", int'(gameOver), int'(modelOver()));
    endtask

    // Inputs already set on the falling edge
    task automatic runCycle();
        @(posedge clkPaddle);
        advanceModel();
        @(negedge clkPaddle);
        checkState();
    endtask

    task automatic storeCase(input int op, input int a, input int b, input int c,
                             input int d, input int e, input int f);
        caseQ.push_back(op);
        caseQ.push_back(a);
        caseQ.push_back(b);
        caseQ.push_back(c);
        caseQ.push_back(d);
        caseQ.push_back(e);
        caseQ.push_back(f);
    endtask

    // Limit from case count plus run lengths
    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clkPaddle);
        $display("Timeout after %0d cycles with cases still running", watchdogCycles);
        $display("STATUS: FAIL");
        $fatal(1);
    end

    initial begin
        int fd;
        int n;
        int op;
        int a;
        int b;
        int c;
        int d;
        int e;
        int f;
        int base;
        int runTotal;
        int caseCount;
        logic [8*8-1:0] opText;
        logic [8*200-1:0] lineBuf;
        rstN = 1'b0;
        sw = 1'b0;
        btnU = 1'b0;
        btnD = 1'b0;
        num = 4'd0;
        x = '0;
        y = '0;
        runTotal = 0;
        fd = $fopen("airHockeyCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open airHockeyCases.txt for reading");
            $display("STATUS: FAIL");
            $fatal(1);
        end
        // Comment lines start with a lone #
        while ($fgets(lineBuf, fd) != 0) begin
            n = $sscanf(lineBuf, "%s", opText);
            if (n == 1 && opText != "#") begin
                if (opText == "step") begin
                    n = $sscanf(lineBuf, "%s %d %d %d %d %d %d", opText, a, b, c, d, e, f);
                    storeCase(OpStep, a, b, c, d, e, f);
                end else if (opText == "probe") begin
                    n = $sscanf(lineBuf, "%s %d %d %h", opText, a, b, c);
                    storeCase(OpProbe, a, b, c, 0, 0, 0);
                end else if (opText == "run") begin
                    n = $sscanf(lineBuf, "%s %d %d", opText, a, b);
                    storeCase(OpRun, a, b, 0, 0, 0, 0);
                    runTotal += a;
                end else begin
                    $display("Unknown operation in airHockeyCases.txt: %0s", opText);
                    $display("STATUS: FAIL");
                    $fatal(1);
                end
            end
        end
        $fclose(fd);
        caseCount = caseQ.size() / CaseFields;
        watchdogCycles = (caseCount + 1) * 200 + runTotal;

        // Reset for 8 cycles
        repeat (8) @(negedge clkPaddle);
        rstN = 1'b1;
        resetModel();
        modelUserPadY = CentreY;
        modelAudioPadY = CentreY;
        checkState();
        checkValue("userPaddleY", int'(userPaddleY), CentreY);
        checkValue("audioPaddleY", int'(audioPaddleY), CentreY);

        for (int idx = 0; idx < caseCount; idx++) begin
            base = idx * CaseFields;
            op = caseQ[base];
            a = caseQ[base + 1];
            b = caseQ[base + 2];
            c = caseQ[base + 3];
            d = caseQ[base + 4];
            e = caseQ[base + 5];
            f = caseQ[base + 6];
            if (op == OpStep) begin
                sw = a[0];
                btnU = b[0];
                btnD = c[0];
                num = d[3:0];
                runCycle();
                checkValue("userPaddleY", int'(userPaddleY), e);
                checkValue("audioPaddleY", int'(audioPaddleY), f);
                // Paddle rows the puck sees from the next step on
                modelUserPadY = e;
                modelAudioPadY = f;
            end else if (op == OpProbe) begin
                x = a[CoordWidth-1:0];
                y = b[CoordWidth-1:0];
                runCycle();
                checkValue("pixelColour", int'(pixelColour), c);
            end else begin
                repeat (a) runCycle();
                checkValue("gameOver", int'(gameOver), b);
            end
        end

        if (caseCount == 0) begin
            $display("No cases found in airHockeyCases.txt");
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// ==== tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen #(
    parameter int PeriodNs = 4
) (
    output logic clkPaddle
);

    // Free running game clock, starts low
    initial begin
        clkPaddle = 1'b0;
    end

    always #(PeriodNs / 2) clkPaddle = ~clkPaddle;

endmodule

// ==== airHockeyTop.sv ====
`timescale 1ns/1ps

module airHockeyTop #(
    parameter int PaddleStep = 6,
    parameter int AudioStep = 3,
    parameter int MaxScore = 7
) (
    input  logic                                clkPaddle,
    input  logic                                rstN,
    input  logic                                sw,
    input  logic                                btnU,
    input  logic                                btnD,
    input  logic [3:0]                          num,
    input  logic [airHockeyPkg::CoordWidth-1:0] x,
    input  logic [airHockeyPkg::CoordWidth-1:0] y,
    output logic [15:0]                         pixelColour,
    output logic [airHockeyPkg::CoordWidth-1:0] userPaddleY,
    output logic [airHockeyPkg::CoordWidth-1:0] audioPaddleY,
    output logic [airHockeyPkg::CoordWidth-1:0] puckX,
    output logic [airHockeyPkg::CoordWidth-1:0] puckY,
    output logic [3:0]                          userScore,
    output logic [3:0]                          audioScore,
    output logic                                gameOver
);
    // Paddle box hits for the current pixel
    logic userPaddleAppear;
    logic audioPaddleAppear;
    // Goal strobes, puck to score keeper
    logic userGoal;
    logic audioGoal;

    airHockeyPaddles #(
        .PaddleStep(PaddleStep),
        .AudioStep(AudioStep)
    ) airHockeyPaddles_i (
        .clkPaddle(clkPaddle), .rstN(rstN), .sw(sw), .btnU(btnU), .btnD(btnD),
        .num(num), .x(x), .y(y), .userPaddleY(userPaddleY), .audioPaddleY(audioPaddleY),
        .userPaddleAppear(userPaddleAppear), .audioPaddleAppear(audioPaddleAppear)
    );

    airHockeyPuck airHockeyPuck_i (
        .clkPaddle(clkPaddle), .rstN(rstN), .sw(sw), .gameOver(gameOver),
        .userPaddleY(userPaddleY), .audioPaddleY(audioPaddleY), .puckX(puckX),
        .puckY(puckY), .userGoal(userGoal), .audioGoal(audioGoal)
    );

    airHockeyScore #(
        .MaxScore(MaxScore)
    ) airHockeyScore_i (
        .clkPaddle(clkPaddle), .rstN(rstN), .sw(sw), .userGoal(userGoal),
        .audioGoal(audioGoal), .userScore(userScore), .audioScore(audioScore),
        .gameOver(gameOver)
    );

    airHockeyRenderer airHockeyRenderer_i (
        .x(x), .y(y), .puckX(puckX), .puckY(puckY), .userPaddleAppear(userPaddleAppear),
        .audioPaddleAppear(audioPaddleAppear), .pixelColour(pixelColour)
    );

endmodule

// ==== airHockeyRenderer.sv ====
`timescale 1ns/1ps

module airHockeyRenderer (
    input  logic [airHockeyPkg::CoordWidth-1:0] x,
    input  logic [airHockeyPkg::CoordWidth-1:0] y,
    input  logic [airHockeyPkg::CoordWidth-1:0] puckX,
    input  logic [airHockeyPkg::CoordWidth-1:0] puckY,
    input  logic                                userPaddleAppear,
    input  logic                                audioPaddleAppear,
    output logic [15:0]                         pixelColour
);
    import airHockeyPkg::*;

    logic puckAppear;
    logic lineAppear;

    //////////////////////////////////////////////////
    // Pixel classification
    //////////////////////////////////////////////////

    // 2x2 puck with its corner at (puckX, puckY)
    assign puckAppear = (x == puckX || x == puckX + CoordWidth'(1))
                     && (y == puckY || y == puckY + CoordWidth'(1));

    // Dashed centre line, two columns wide
    assign lineAppear = (x == CoordWidth'(CentreX - 1) || x == CoordWidth'(CentreX))
                     && !y[0];

    // Puck drawn over everything else
    always_comb begin
        if (puckAppear) begin
            pixelColour = ColourWhite;
        end else if (userPaddleAppear) begin
            pixelColour = ColourRed;
        end else if (audioPaddleAppear) begin
            pixelColour = ColourBlue;
        end else if (lineAppear) begin
            pixelColour = ColourGrey;
        end else begin
            pixelColour = ColourBlack;
        end
    end

endmodule

// ==== airHockeyScore.sv ====
`timescale 1ns/1ps

module airHockeyScore #(
    parameter int MaxScore = 7
) (
    input  logic       clkPaddle,
    input  logic       rstN,
    input  logic       sw,
    input  logic       userGoal,
    input  logic       audioGoal,
    output logic [3:0] userScore,
    output logic [3:0] audioScore,
    output logic       gameOver
);
    localparam logic [3:0] ScoreLimit = 4'(MaxScore);

    // Level, stays up until sw drops and clears the counters
    assign gameOver = (userScore >= ScoreLimit) || (audioScore >= ScoreLimit);

    //////////////////////////////////////////////////
    // Goal counters
    //////////////////////////////////////////////////

    always_ff @(posedge clkPaddle or negedge rstN) begin
        if (!rstN) begin
            userScore <= 4'd0;
            audioScore <= 4'd0;
        end else if (!sw) begin
            userScore <= 4'd0;
            audioScore <= 4'd0;
        end else if (!gameOver) begin
            if (userGoal) begin
                userScore <= userScore + 4'd1;
            end
            if (audioGoal) begin
                audioScore <= audioScore + 4'd1;
            end
        end
    end

    // Puck can only be at one edge per step
    goalExclusiveA: assert property (@(posedge clkPaddle) disable iff (!rstN)
        !(userGoal && audioGoal) && userScore <= ScoreLimit && audioScore <= ScoreLimit)
        else $error("double goal or score past limit");

endmodule

// ==== airHockeyPuck.sv ====
`timescale 1ns/1ps

module airHockeyPuck (
    input  logic                                clkPaddle,
    input  logic                                rstN,
    input  logic                                sw,
    input  logic                                gameOver,
    input  logic [airHockeyPkg::CoordWidth-1:0] userPaddleY,
    input  logic [airHockeyPkg::CoordWidth-1:0] audioPaddleY,
    output logic [airHockeyPkg::CoordWidth-1:0] puckX,
    output logic [airHockeyPkg::CoordWidth-1:0] puckY,
    output logic                                userGoal,
    output logic                                audioGoal
);
    import airHockeyPkg::*;

    // Puck is 2x2, so its corner stops 2 short of the far edge
    localparam int PuckMaxX = ScreenWidth - 2;
    localparam int PuckMaxY = ScreenHeight - 2;
    // Columns where the puck touches a paddle face
    localparam int UserHitX = UserPaddleX + 2;
    localparam int AudioHitX = AudioPaddleX - 3;

    // dx is -1 while dxLeft and dy is -1 while dyUp
    logic dxLeft;
    logic dyUp;

    logic leftGoal;
    logic rightGoal;
    logic userHit;
    logic audioHit;
    logic dxLeftNext;
    logic dyUpNext;
    int yAhead;
    logic [CoordWidth-1:0] xNext;
    logic [CoordWidth-1:0] yNext;

    // Puck row within reach of a paddle centre
    function automatic logic nearPaddle(
        input logic [CoordWidth-1:0] py,
        input logic [CoordWidth-1:0] padY
    );
        return (int'(py) >= int'(padY) - PaddleHalfHeight)
            && (int'(py) <= int'(padY) + PaddleHalfHeight);
    endfunction

    //////////////////////////////////////////////////
    // Next step
    //////////////////////////////////////////////////

    // Edge reached in the direction of travel
    assign leftGoal = dxLeft && (puckX == '0);
    assign rightGoal = !dxLeft && (puckX == CoordWidth'(PuckMaxX));

    // Paddle contact only counts when heading into the paddle
    assign userHit = dxLeft && (puckX == CoordWidth'(UserHitX))
                  && nearPaddle(puckY, userPaddleY);
    assign audioHit = !dxLeft && (puckX == CoordWidth'(AudioHitX))
                   && nearPaddle(puckY, audioPaddleY);

    // Wall check looks one row ahead and flips before moving
    assign yAhead = dyUp ? int'(puckY) - 1 : int'(puckY) + 1;
    assign dyUpNext = (yAhead < 1 || yAhead > PuckMaxY) ? !dyUp : dyUp;
    assign dxLeftNext = (userHit || audioHit) ? !dxLeft : dxLeft;

    assign xNext = dxLeftNext ? puckX - CoordWidth'(1) : puckX + CoordWidth'(1);
    assign yNext = dyUpNext ? puckY - CoordWidth'(1) : puckY + CoordWidth'(1);

    always_ff @(posedge clkPaddle or negedge rstN) begin
        if (!rstN) begin
            puckX <= CoordWidth'(CentreX);
            puckY <= CoordWidth'(CentreY);
            dxLeft <= 1'b1;
            dyUp <= 1'b0;
            userGoal <= 1'b0;
            audioGoal <= 1'b0;
        end else if (!sw) begin
            // Serve position heading left and down
            puckX <= CoordWidth'(CentreX);
            puckY <= CoordWidth'(CentreY);
            dxLeft <= 1'b1;
            dyUp <= 1'b0;
            userGoal <= 1'b0;
            audioGoal <= 1'b0;
        end else begin
            // Strobes last a single cycle
            userGoal <= 1'b0;
            audioGoal <= 1'b0;
            // Frozen once the match is decided
            if (!gameOver) begin
                if (leftGoal) begin
                    audioGoal <= 1'b1;
                    puckX <= CoordWidth'(CentreX);
                    puckY <= CoordWidth'(CentreY);
                    dxLeft <= 1'b0;
                end else if (rightGoal) begin
                    userGoal <= 1'b1;
                    puckX <= CoordWidth'(CentreX);
                    puckY <= CoordWidth'(CentreY);
                    dxLeft <= 1'b1;
                end else begin
                    puckX <= xNext;
                    puckY <= yNext;
                    dxLeft <= dxLeftNext;
                    dyUp <= dyUpNext;
                end
            end
        end
    end

    puckRangeA: assert property (@(posedge clkPaddle) disable iff (!rstN)
        puckX <= CoordWidth'(PuckMaxX) && puckY <= CoordWidth'(PuckMaxY))
        else $error("puck left the playfield");

endmodule

// ==== airHockeyPaddles.sv ====
`timescale 1ns/1ps

module airHockeyPaddles #(
    parameter int PaddleStep = 6,
    parameter int AudioStep = 3
) (
    input  logic                                clkPaddle,
    input  logic                                rstN,
    input  logic                                sw,
    input  logic                                btnU,
    input  logic                                btnD,
    input  logic [3:0]                          num,
    input  logic [airHockeyPkg::CoordWidth-1:0] x,
    input  logic [airHockeyPkg::CoordWidth-1:0] y,
    output logic [airHockeyPkg::CoordWidth-1:0] userPaddleY,
    output logic [airHockeyPkg::CoordWidth-1:0] audioPaddleY,
    output logic                                userPaddleAppear,
    output logic                                audioPaddleAppear
);
    import airHockeyPkg::*;

    // Audio paddle centre at zero volume
    localparam int AudioBaseY = ScreenHeight - PaddleHalfHeight;

    logic [CoordWidth-1:0] userNextY;
    logic [CoordWidth-1:0] audioNextY;
    int audioRaw;

    // True when (px, py) falls in the paddle box at column colX
    function automatic logic paddleHit(
        input logic [CoordWidth-1:0] px,
        input logic [CoordWidth-1:0] py,
        input int colX,
        input logic [CoordWidth-1:0] centreY
    );
        logic inX;
        logic inY;
        inX = (int'(px) >= colX - PaddleHalfWidth) && (int'(px) <= colX + PaddleHalfWidth);
        inY = (int'(py) >= int'(centreY) - PaddleHalfHeight)
           && (int'(py) <= int'(centreY) + PaddleHalfHeight);
        return inX && inY;
    endfunction

    //////////////////////////////////////////////////
    // User paddle, button driven
    //////////////////////////////////////////////////

    always_comb begin
        userNextY = userPaddleY;
        // Up wins when both buttons held
        if (btnU) begin
            if (int'(userPaddleY) - PaddleStep < PaddleMinY) begin
                userNextY = CoordWidth'(PaddleMinY);
            end else begin
                userNextY = userPaddleY - CoordWidth'(PaddleStep);
            end
        end else if (btnD) begin
            if (int'(userPaddleY) + PaddleStep > PaddleMaxY) begin
                userNextY = CoordWidth'(PaddleMaxY);
            end else begin
                userNextY = userPaddleY + CoordWidth'(PaddleStep);
            end
        end
    end

    //////////////////////////////////////////////////
    // Audio paddle, louder means higher
    //////////////////////////////////////////////////

    assign audioRaw = AudioBaseY - AudioStep * int'(num);
    // Clamp at the top of the screen only
    assign audioNextY = (audioRaw < PaddleMinY) ? CoordWidth'(PaddleMinY)
                                                : CoordWidth'(audioRaw);

    // Both paddles re-centre while the game is switched off
    always_ff @(posedge clkPaddle or negedge rstN) begin
        if (!rstN) begin
            userPaddleY <= CoordWidth'(CentreY);
            audioPaddleY <= CoordWidth'(CentreY);
        end else if (!sw) begin
            userPaddleY <= CoordWidth'(CentreY);
            audioPaddleY <= CoordWidth'(CentreY);
        end else begin
            userPaddleY <= userNextY;
            audioPaddleY <= audioNextY;
        end
    end

    // Pixel hit tests for the renderer
    assign userPaddleAppear = paddleHit(x, y, UserPaddleX, userPaddleY);
    assign audioPaddleAppear = paddleHit(x, y, AudioPaddleX, audioPaddleY);

    // Audio paddle may sit one row lower, at zero volume
    paddleRangeA: assert property (@(posedge clkPaddle) disable iff (!rstN)
        userPaddleY >= CoordWidth'(PaddleMinY) && userPaddleY <= CoordWidth'(PaddleMaxY)
        && audioPaddleY >= CoordWidth'(PaddleMinY) && audioPaddleY <= CoordWidth'(AudioBaseY))
        else $error("paddle centre out of range");

endmodule

// ==== airHockeyPkg.sv ====
package airHockeyPkg;

    //////////////////////////////////////////////////
    // Screen geometry
    //////////////////////////////////////////////////

    // Coordinate bits, enough for 0..127
    localparam int CoordWidth = 7;

    // OLED panel size in pixels
    localparam int ScreenWidth = 96;
    localparam int ScreenHeight = 64;

    // Paddle is 3 wide and 21 tall around its centre
    localparam int PaddleHalfHeight = 10;
    localparam int PaddleHalfWidth = 1;

    // Gap between paddle column and screen edge
    localparam int Border = 3;
    localparam int UserPaddleX = Border;
    localparam int AudioPaddleX = ScreenWidth - Border - 1;

    // Centre of the playfield
    localparam int CentreX = ScreenWidth / 2;
    localparam int CentreY = ScreenHeight / 2;

    // Paddle centre limits, keeps the whole paddle on screen
    localparam int PaddleMinY = PaddleHalfHeight;
    localparam int PaddleMaxY = ScreenHeight - 1 - PaddleHalfHeight;

    //////////////////////////////////////////////////
    // RGB565 colours
    //////////////////////////////////////////////////

    localparam logic [15:0] ColourRed = 16'b11111_000000_00000;
    localparam logic [15:0] ColourBlue = 16'b00000_000000_11111;
    localparam logic [15:0] ColourWhite = 16'b11111_111111_11111;
    localparam logic [15:0] ColourGrey = 16'b10000_100000_10000;
    localparam logic [15:0] ColourBlack = 16'b00000_000000_00000;

endpackage
